/* logic/motor_pkg.sv */
// Motor drive package with shared constants, bridge and decay encodings and the command format
package motor_pkg;

	// Width of the PWM phase counter and of the duty level
	localparam int pwm_bits = 9;

	// One PWM period in clocks, since there is no prescaler ahead of the counter
	localparam int pwm_period = 512;

	// Phase at which a pending command is copied into the active set
	// Two clocks before the wrap, so the new level is in place for phase 0
	localparam int apply_phase = 510;

	// Dead time in clocks, added only to the inverted-side threshold
	// Active-side-only modes (fast drive and fast brake) are unaffected by it
	localparam int dead_time = 10;

	// Depth of the Hall input synchroniser
	localparam int hall_sync_stages = 2;

	// Gate code for one half-bridge
	// The low bit drives the low-side FET and the high bit the high-side FET
	// noff is what off turns into after a bitwise inversion and it also means open
	typedef enum logic [1:0] {
		off  = 2'b00,
		low  = 2'b01,
		high = 2'b10,
		noff = 2'b11
	} bridge_code_t;

	// Current decay behaviour outside the PWM on-time
	typedef enum logic [1:0] {
		// Recirculate through the low sides after the dead time
		slow_decay = 2'b00,
		// Drive the pattern during on-time and leave the bridge open otherwise
		fast_drive = 2'b01,
		// Short the driven windings to ground during on-time
		fast_brake = 2'b10
	} decay_mode_t;

	// Motor command as sent by the CPU
	// Twelve bits with the direction in the MSB
	typedef struct packed {
		logic                direction;
		logic [pwm_bits-1:0] level;
		decay_mode_t         mode;
	} motor_cmd_t;

	// One code for each of the three phases
	// Used both for the commutation pattern and for the registered gate outputs
	typedef struct packed {
		bridge_code_t phase_a;
		bridge_code_t phase_b;
		bridge_code_t phase_c;
	} bridge_set_t;

endpackage

/* logic/pwm_timebase.sv */
// PWM time base with a free-running phase counter and a period strobe for command updates
module pwm_timebase (
	input  logic                           clk,
	input  logic                           rst,
	output logic [motor_pkg::pwm_bits-1:0] phase,
	output logic                           period_start
);

	import motor_pkg::*;

	// Phase counter
	// It wraps at the end of the period, so with a power-of-two period this is a
	// plain binary rollover, but the explicit compare keeps it correct otherwise
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else if (phase == pwm_bits'(pwm_period - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Period strobe decoded from the registered phase
	// It is high for exactly one clock per period, on the clock whose edge
	// moves the phase from apply_phase to apply_phase + 1
	// Commands loaded on that edge are therefore in place before phase 0
	// Since the counter resets to 0 the strobe is low throughout reset
	// The top level also exports it as an ADC trigger
	assign period_start = (phase == pwm_bits'(apply_phase));

endmodule

/* logic/motor_control.sv */
// Motor command control that buffers one command and applies it once per PWM period
module motor_control (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           cmd_valid,
	input  motor_pkg::motor_cmd_t          cmd,
	output logic                           cmd_ready,
	input  logic                           period_start,
	input  logic                           hall_fault,
	output logic                           direction,
	output logic [motor_pkg::pwm_bits-1:0] level,
	output motor_pkg::decay_mode_t         mode,
	output logic                           drive_en
);

	import motor_pkg::*;

	// One-deep pending buffer
	logic       pend_valid;
	motor_cmd_t pend_cmd;

	// Command currently driving the bridge
	motor_cmd_t act_cmd;

	// Set once the first command has reached the active register
	logic applied;

	// Handshake and update strobes
	logic cmd_fire;
	logic apply_now;

	// Ready whenever the pending slot is empty
	// A transfer fills the slot so ready drops on the next cycle
	assign cmd_ready = !pend_valid;
	assign cmd_fire  = cmd_valid && cmd_ready;

	// The pending command moves to active only at the period boundary
	// so a level change never cuts a PWM pulse short
	assign apply_now = period_start && pend_valid;

	// Pending flag
	// A transfer and an apply cannot coincide because ready is low whenever
	// the slot is full
	// A transfer on the strobe edge itself waits for the next period
	always_ff @(posedge clk) begin
		if (rst) begin
			pend_valid <= 1'b0;
		end else if (cmd_fire) begin
			pend_valid <= 1'b1;
		end else if (period_start) begin
			pend_valid <= 1'b0;
		end
	end

	// Pending payload, only meaningful while pend_valid is set
	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			pend_cmd <= cmd;
		end
	end

	// Active command
	// After reset the motor is stopped with zero duty and slow decay
	always_ff @(posedge clk) begin
		if (rst) begin
			act_cmd <= '{direction: 1'b0, level: '0, mode: slow_decay};
		end else if (apply_now) begin
			act_cmd <= pend_cmd;
		end
	end

	// The bridge stays open until the CPU has issued at least one command
	always_ff @(posedge clk) begin
		if (rst) begin
			applied <= 1'b0;
		end else if (apply_now) begin
			applied <= 1'b1;
		end
	end

	assign direction = act_cmd.direction;
	assign level     = act_cmd.level;
	assign mode      = act_cmd.mode;

	// Fault blocks the drive for as long as it lasts
	// hall_fault is already registered, so this stays combinational to meet
	// the one-cycle fault-to-output latency
	assign drive_en = applied && !hall_fault;

endmodule

/* logic/commutator.sv */
// Six-step commutator with Hall synchroniser, direction reversal and invalid-code fault
module commutator (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [2:0]             hall,
	input  logic                   direction,
	output motor_pkg::bridge_set_t pattern,
	output logic                   hall_fault
);

	import motor_pkg::*;

	// Synchroniser chain, index 0 samples the pins
	logic [hall_sync_stages-1:0][2:0] hall_sync;

	// Synchronised code and its forward-direction pattern
	logic [2:0]  hall_now;
	bridge_set_t fwd;

	// The chain keeps sampling during reset so the first code after reset is real
	always_ff @(posedge clk) begin
		hall_sync <= {hall_sync[hall_sync_stages-2:0], hall};
	end

	assign hall_now = hall_sync[hall_sync_stages-1];

	// Forward commutation table
	// Each valid state drives one phase high, one low and leaves one open
	always_comb begin
		case (hall_now)
			3'b101:  fwd = '{phase_a: high, phase_b: low,  phase_c: off};
			3'b100:  fwd = '{phase_a: high, phase_b: off,  phase_c: low};
			3'b110:  fwd = '{phase_a: off,  phase_b: high, phase_c: low};
			3'b010:  fwd = '{phase_a: low,  phase_b: high, phase_c: off};
			3'b011:  fwd = '{phase_a: low,  phase_b: off,  phase_c: high};
			3'b001:  fwd = '{phase_a: off,  phase_b: low,  phase_c: high};
			// 000 and 111 cannot occur on a healthy sensor set
			default: fwd = '{phase_a: off,  phase_b: off,  phase_c: off};
		endcase
	end

	// Reverse rotation swaps high and low on every phase
	// Open phases become noff, which the bridge driver treats as open
	assign pattern = direction ? bridge_set_t'(~fwd) : fwd;

	// Fault flag
	// It is loaded from the stage before hall_now, so it changes on the same
	// edge as the decoded pattern
	// A stuck-at fault on one or two sensors can still yield valid codes, the
	// CPU catches that case as a stall
	always_ff @(posedge clk) begin
		if (rst) begin
			hall_fault <= 1'b0;
		end else begin
			hall_fault <= (hall_sync[hall_sync_stages-2] == 3'b000) ||
				(hall_sync[hall_sync_stages-2] == 3'b111);
		end
	end

endmodule

/* logic/bridge_driver.sv */
// Bridge driver applying PWM, dead time and decay mode to the pattern, with registered gates
module bridge_driver (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [motor_pkg::pwm_bits-1:0] phase,
	input  logic [motor_pkg::pwm_bits-1:0] level,
	input  motor_pkg::decay_mode_t         mode,
	input  logic                           drive_en,
	input  motor_pkg::bridge_set_t         pattern,
	output motor_pkg::bridge_set_t         bridge_out
);

	import motor_pkg::*;

	// PWM window flags shared by all three phases
	logic              pwm_active;
	logic              pwm_inverted;
	logic [pwm_bits:0] inv_threshold;

	// Gate codes before the output register
	bridge_set_t gate_next;

	// Gate code for a single half-bridge
	function automatic bridge_code_t half_bridge(
		input bridge_code_t code,
		input logic         act,
		input logic         inv,
		input decay_mode_t  dm
	);
		bridge_code_t clean;
		logic         driven;
		bridge_code_t result;
		// noff only comes from direction reversal and must stay open
		clean  = (code == noff) ? off : code;
		driven = (clean == high) || (clean == low);
		case (dm)
			slow_decay: begin
				if (act) begin
					result = clean;
				end else if (inv && driven) begin
					result = low;
				end else begin
					result = off;
				end
			end
			fast_drive: result = act ? clean : off;
			// Both driven windings go to ground, open phases stay open
			fast_brake: result = (act && driven) ? low : off;
			default:    result = off;
		endcase
		return result;
	endfunction

	// On-time covers phases 0 to level - 1, so level counts on-cycles
	assign pwm_active = (phase < level);

	// The low-side window starts dead_time cycles after the on-time ends
	// One extra bit keeps a high level from wrapping into a short threshold
	assign inv_threshold = {1'b0, level} + (pwm_bits + 1)'(dead_time);
	assign pwm_inverted  = ({1'b0, phase} >= inv_threshold);

	assign gate_next.phase_a = half_bridge(pattern.phase_a, pwm_active, pwm_inverted, mode);
	assign gate_next.phase_b = half_bridge(pattern.phase_b, pwm_active, pwm_inverted, mode);
	assign gate_next.phase_c = half_bridge(pattern.phase_c, pwm_active, pwm_inverted, mode);

	// Output register so the gates never see decode glitches
	// Disabling the drive opens every half-bridge on the next edge
	always_ff @(posedge clk) begin
		if (rst) begin
			bridge_out <= '{phase_a: off, phase_b: off, phase_c: off};
		end else if (!drive_en) begin
			bridge_out <= '{phase_a: off, phase_b: off, phase_c: off};
		end else begin
			bridge_out <= gate_next;
		end
	end

endmodule

/* logic/motor_drive.sv */
// Three-phase BLDC drive top level joining command control, commutation and PWM bridge driver
module motor_drive (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cmd_valid,
	input  motor_pkg::motor_cmd_t  cmd,
	output logic                   cmd_ready,
	input  logic [2:0]             hall,
	output motor_pkg::bridge_set_t bridge_out,
	output logic                   fault,
	output logic                   period_start
);

	import motor_pkg::*;

	// PWM phase shared by the control strobe and the comparators
	logic [pwm_bits-1:0] phase;

	// Active command fields
	logic                direction;
	logic [pwm_bits-1:0] level;
	decay_mode_t         mode;
	logic                drive_en;

	// Commutation pattern before PWM gating
	bridge_set_t pattern;

	pwm_timebase u_timebase (
		.clk          (clk),
		.rst          (rst),
		.phase        (phase),
		.period_start (period_start)
	);

	// The registered Hall fault is exported as is and also blocks the drive
	motor_control u_control (
		.clk          (clk),
		.rst          (rst),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.cmd_ready    (cmd_ready),
		.period_start (period_start),
		.hall_fault   (fault),
		.direction    (direction),
		.level        (level),
		.mode         (mode),
		.drive_en     (drive_en)
	);

	commutator u_commutator (
		.clk        (clk),
		.rst        (rst),
		.hall       (hall),
		.direction  (direction),
		.pattern    (pattern),
		.hall_fault (fault)
	);

	bridge_driver u_bridge (
		.clk        (clk),
		.rst        (rst),
		.phase      (phase),
		.level      (level),
		.mode       (mode),
		.drive_en   (drive_en),
		.pattern    (pattern),
		.bridge_out (bridge_out)
	);

endmodule

/* tests/motor_drive_checker.sv */
// Bound assertion checker for the motor drive covering gate legality, handshake, PWM and fault
module motor_drive_checker (
	input logic                           clk,
	input logic                           rst,
	input logic                           cmd_valid,
	input logic                           cmd_ready,
	input logic                           period_start,
	input logic                           fault,
	input logic [2:0]                     hall,
	input logic [motor_pkg::pwm_bits-1:0] phase,
	input logic [motor_pkg::pwm_bits-1:0] level,
	input motor_pkg::decay_mode_t         mode,
	input motor_pkg::bridge_set_t         bridge_out
);

	timeunit 1ns;
	timeprecision 1ns;

	import motor_pkg::*;

	// Number of assertion failures, read by the testbench at the end of the run
	int fail_count = 0;

	// Summary flags over the three gate codes
	logic              any_noff;
	logic              any_high;
	logic              all_off;
	logic              hall_bad;
	logic [pwm_bits:0] inv_threshold;

	assign any_noff = (bridge_out.phase_a == noff) || (bridge_out.phase_b == noff) ||
		(bridge_out.phase_c == noff);
	assign any_high = (bridge_out.phase_a == high) || (bridge_out.phase_b == high) ||
		(bridge_out.phase_c == high);
	assign all_off = (bridge_out.phase_a == off) && (bridge_out.phase_b == off) &&
		(bridge_out.phase_c == off);
	assign hall_bad = (hall == 3'b000) || (hall == 3'b111);

	// Start of the low-side window in slow decay
	assign inv_threshold = {1'b0, level} + 10'd10;

	// The reserved code never reaches the gates
	no_noff: assert property (@(posedge clk) !any_noff)
		else begin $error("bridge_out shows the reserved open code"); fail_count++; end

	// Reset opens every half-bridge
	reset_off: assert property (@(posedge clk) rst |=> all_off)
		else begin $error("bridge_out not open after a reset cycle"); fail_count++; end

	// A fault opens the bridge through the output register
	fault_off: assert property (@(posedge clk) disable iff (rst) fault |=> all_off)
		else begin $error("bridge_out driven while fault was high"); fail_count++; end

	// Fault trails the Hall pins by the synchroniser depth
	fault_delay: assert property (@(posedge clk) disable iff (rst) fault == $past(hall_bad, 2))
		else begin $error("fault does not follow an invalid Hall code"); fail_count++; end

	// Handshake timing of cmd_ready
	ready_drop: assert property (@(posedge clk) disable iff (rst)
		cmd_valid && cmd_ready |=> !cmd_ready)
		else begin $error("cmd_ready stayed high after a transfer"); fail_count++; end
	ready_hold: assert property (@(posedge clk) disable iff (rst)
		!cmd_ready && !period_start |=> !cmd_ready)
		else begin $error("cmd_ready rose away from period_start"); fail_count++; end
	ready_rise: assert property (@(posedge clk) disable iff (rst)
		!cmd_ready && period_start |=> cmd_ready)
		else begin $error("cmd_ready did not rise after period_start"); fail_count++; end

	// High side only during the on-time in every mode
	on_time: assert property (@(posedge clk) disable iff (rst) (phase >= level) |=> !any_high)
		else begin $error("high side driven outside the on-time"); fail_count++; end

	// Fast drive leaves the bridge open outside the on-time
	drive_open: assert property (@(posedge clk) disable iff (rst)
		(mode == fast_drive) && (phase >= level) |=> all_off)
		else begin $error("fast drive not open outside the on-time"); fail_count++; end

	// Slow decay keeps the dead time before the low-side window
	dead_gap: assert property (@(posedge clk) disable iff (rst)
		(mode == slow_decay) && (phase >= level) && ({1'b0, phase} < inv_threshold)
		|=> all_off)
		else begin $error("low side driven inside the dead time"); fail_count++; end

	// Fast brake never uses a high side
	brake_low: assert property (@(posedge clk) disable iff (rst)
		(mode == fast_brake) |=> !any_high)
		else begin $error("high side driven in fast brake"); fail_count++; end

endmodule

bind motor_drive motor_drive_checker checks (
	.clk          (clk),
	.rst          (rst),
	.cmd_valid    (cmd_valid),
	.cmd_ready    (cmd_ready),
	.period_start (period_start),
	.fault        (fault),
	.hall         (hall),
	.phase        (phase),
	.level        (level),
	.mode         (mode),
	.bridge_out   (bridge_out)
);

/* tests/tb_motor_drive.sv */
// Testbench for the BLDC motor drive with commutation, handshake, PWM and fault stimulus
module tb_motor_drive;

	timeunit 1ns;
	timeprecision 1ns;

	import motor_pkg::*;

	// Longest wait for a handshake event, two PWM periods
	localparam int wait_limit = 2 * 512;

	logic        clk;
	logic        rst;
	logic        cmd_valid;
	motor_cmd_t  cmd;
	logic        cmd_ready;
	logic [2:0]  hall;
	bridge_set_t bridge_out;
	logic        fault;
	logic        period_start;

	int seed;
	int protocol_errors = 0;
	int value_errors = 0;

	// The six valid Hall states
	logic [2:0] valid_codes [6] = '{3'b101, 3'b100, 3'b110, 3'b010, 3'b011, 3'b001};

	motor_drive UUT (
		.clk          (clk),
		.rst          (rst),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.cmd_ready    (cmd_ready),
		.hall         (hall),
		.bridge_out   (bridge_out),
		.fault        (fault),
		.period_start (period_start)
	);

	always #50 clk = ~clk;

	// Expected gates at full duty in fast drive
	// Reverse rotation swaps high and low and shows open phases as off
	function automatic bridge_set_t table_pattern(input logic [2:0] code, input logic dir);
		bridge_set_t t;
		case (code)
			3'b101:  t = '{phase_a: high, phase_b: low,  phase_c: off};
			3'b100:  t = '{phase_a: high, phase_b: off,  phase_c: low};
			3'b110:  t = '{phase_a: off,  phase_b: high, phase_c: low};
			3'b010:  t = '{phase_a: low,  phase_b: high, phase_c: off};
			3'b011:  t = '{phase_a: low,  phase_b: off,  phase_c: high};
			3'b001:  t = '{phase_a: off,  phase_b: low,  phase_c: high};
			default: t = '{phase_a: off,  phase_b: off,  phase_c: off};
		endcase
		if (dir) begin
			t.phase_a = (t.phase_a == high) ? low : (t.phase_a == low) ? high : off;
			t.phase_b = (t.phase_b == high) ? low : (t.phase_b == low) ? high : off;
			t.phase_c = (t.phase_c == high) ? low : (t.phase_c == low) ? high : off;
		end
		return t;
	endfunction

	function automatic int code_count(input bridge_set_t b, input bridge_code_t code);
		return int'(b.phase_a == code) + int'(b.phase_b == code) + int'(b.phase_c == code);
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
			value_errors++;
		end
	endtask

	// Offer a command and follow it until it is active
	task automatic send_cmd(input logic dir, input logic [8:0] lvl, input decay_mode_t m);
		int waited;
		cmd = '{direction: dir, level: lvl, mode: m};
		cmd_valid = 1'b1;
		waited = 0;
		while (!cmd_ready && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (waited >= wait_limit) begin
			$display("Handshake error: cmd_ready never rose for a waiting command");
			protocol_errors++;
		end
		// The transfer happens on the next rising edge
		@(negedge clk);
		cmd_valid = 1'b0;
		if (cmd_ready) begin
			$display("Handshake error: cmd_ready still high after a transfer");
			protocol_errors++;
		end
		waited = 0;
		while (!period_start && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (waited >= wait_limit) begin
			$display("Handshake error: no period_start while a command was pending");
			protocol_errors++;
		end
		@(negedge clk);
		if (!cmd_ready) begin
			$display("Handshake error: cmd_ready low after period_start");
			protocol_errors++;
		end
	endtask

	// Hold one Hall code and compare the gates once the decode has settled
	task automatic hold_hall(input logic [2:0] code, input logic dir);
		hall = code;
		repeat (3) @(negedge clk);
		repeat (4) begin
			// Phase 0 means the previous phase was 511, outside the on-time
			if (UUT.phase != 0) begin
				check_value("commutation", int'(table_pattern(code, dir)), int'(bridge_out));
			end
			@(negedge clk);
		end
	endtask

	// One full period with a new command, counting the gate states
	task automatic duty_period(input decay_mode_t m);
		logic [8:0] lvl;
		int         n_high;
		int         n_low;
		int         n_two_low;
		int         n_strobe;
		int         strobe_at;
		int         gap;
		int         i;
		lvl = 9'($random(seed));
		send_cmd(1'b0, lvl, m);
		// The first output after the apply edge still uses the old level
		@(negedge clk);
		n_high = 0;
		n_low = 0;
		n_two_low = 0;
		n_strobe = 0;
		strobe_at = -1;
		for (i = 0; i < 512; i++) begin
			if (code_count(bridge_out, high) > 0) n_high++;
			if (code_count(bridge_out, low) > 0) n_low++;
			if (code_count(bridge_out, low) == 2) n_two_low++;
			if (period_start) begin
				n_strobe++;
				strobe_at = i;
			end
			@(negedge clk);
		end
		// The apply strobe came two samples before this window
		// so the next one lands one full period after it
		check_value("period_start_count", 1, n_strobe);
		check_value("period_start_spacing", 512 - 2, strobe_at);
		gap = 512 - int'(lvl) - 10;
		case (m)
			fast_drive: check_value("fast_drive_high", int'(lvl), n_high);
			slow_decay: begin
				check_value("slow_decay_high", int'(lvl), n_high);
				check_value("slow_decay_recirculate", (gap > 0) ? gap : 0, n_two_low);
			end
			default: begin
				check_value("fast_brake_low", int'(lvl), n_low);
				check_value("fast_brake_high", 0, n_high);
			end
		endcase
	endtask

	// Invalid Hall code, then recovery on a valid one
	task automatic fault_round(input logic [2:0] bad);
		hall = bad;
		repeat (2) @(negedge clk);
		check_value("fault_raise", 1, int'(fault));
		@(negedge clk);
		check_value("fault_open", int'(table_pattern(3'b000, 1'b0)), int'(bridge_out));
		hall = 3'b100;
		@(negedge clk);
		check_value("fault_hold", 1, int'(fault));
		@(negedge clk);
		check_value("fault_clear", 0, int'(fault));
		@(negedge clk);
		if (UUT.phase != 0) begin
			check_value("fault_resume", int'(table_pattern(3'b100, 1'b0)), int'(bridge_out));
		end
		repeat (3) @(negedge clk);
	endtask

	// Watchdog sized for forty PWM periods
	initial begin
		#(40 * 512 * 100);
		$display("Watchdog timeout: the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		seed = 32'hcedf_ec23;
		clk = 1'b0;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '{direction: 1'b0, level: '0, mode: slow_decay};
		hall = 3'b101;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		// Commutation in both directions at full duty
		send_cmd(1'b0, 9'd511, fast_drive);
		repeat (12) hold_hall(valid_codes[$unsigned($random(seed)) % 6], 1'b0);
		send_cmd(1'b1, 9'd511, fast_drive);
		repeat (12) hold_hall(valid_codes[$unsigned($random(seed)) % 6], 1'b1);

		// Fault on both invalid codes
		send_cmd(1'b0, 9'd511, fast_drive);
		fault_round(3'b000);
		fault_round(3'b111);

		// Duty, dead time and brake with a fixed Hall state
		hall = 3'b101;
		duty_period(fast_drive);
		duty_period(slow_decay);
		duty_period(fast_brake);
		duty_period(slow_decay);

		$display("Errors: %0d protocol, %0d value, %0d assertion",
			protocol_errors, value_errors, UUT.checks.fail_count);
		if (protocol_errors + value_errors + UUT.checks.fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* all.f */
logic/motor_pkg.sv
logic/pwm_timebase.sv
logic/motor_control.sv
logic/commutator.sv
logic/bridge_driver.sv
logic/motor_drive.sv
tests/motor_drive_checker.sv
tests/tb_motor_drive.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = tb_motor_drive
FILELIST = all.f
RUNARGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNARGS) | tee /dev/stderr | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
